//--- tb/msp430_per_tests.txt
# name op addr data expect, all hex, addr is a byte address, rd data is the external word
# irq and rst take the timeout in cycles as data, ack expects the wdt_irq level after the pulse
wdt_hold    wr  0120 5a80 0000
wdt_hold_rb rd  0120 0000 6980
ext_rd      rd  0200 beef beef
ext_macs    rd  0136 1234 1234
mpy_op1     wr  0130 1234 0000
mpy_op2     wr  0138 5678 0000
mpy_lo      rd  013a 0000 0060
mpy_hi      rd  013c 0000 0626
mpy_sumext  rd  013e 0000 0000
mpy_big1    wr  0130 ffff 0000
mpy_big2    wr  0138 ffff 0000
mpy_big_lo  rd  013a 0000 0001
mpy_big_hi  rd  013c 0000 fffe
mpys_op1    wr  0132 fffe 0000
mpys_op2    wr  0138 0003 0000
mpys_lo     rd  013a 0000 fffa
mpys_hi     rd  013c 0000 ffff
mpys_sumext rd  013e 0000 ffff
mpys_pos1   wr  0138 fffd 0000
mpys_pos_lo rd  013a 0000 0006
mpys_pos_sx rd  013e 0000 0000
mac_prelo   wr  013a ffff 0000
mac_prehi   wr  013c ffff 0000
mac_op1     wr  0134 0002 0000
mac_op2     wr  0138 0003 0000
mac_lo      rd  013a 0000 0005
mac_hi      rd  013c 0000 0000
mac_carry   rd  013e 0000 0001
ie_on       wr  0000 0001 0000
ifg_clear   wr  0002 0000 0000
ie_rb       rd  0000 0000 0001
ivl_cfg     wr  0120 5a1b 0000
ivl_rb      rd  0120 0000 6913
ivl_irq     irq 0000 0064 0000
ivl_ifg     rd  0002 0000 0001
ivl_ack     ack 0000 0000 0000
ivl_ifg_clr rd  0002 0000 0000
bad_pw      wr  0120 1280 0000
bad_pw_rst  rst 0000 0000 0000
bad_pw_rb   rd  0120 0000 6913
wdt_cfg     wr  0120 5a0b 0000
wdt_expire  rst 0000 0064 0000
wdt_cfg_rb  rd  0120 0000 6903
wdt_park    wr  0120 5a80 0000

//--- build.f
hw/msp430_per_pkg.sv
hw/msp430_per_decoder.sv
hw/msp430_watchdog.sv
hw/msp430_multiplier.sv
hw/msp430_per_rdata.sv
hw/msp430_per_top.sv
tb/msp430_per_props.sv
tb/tb_msp430_per.sv

//--- Bender.yml
package:
  name: msp430_per

sources:
  - hw/msp430_per_pkg.sv
  - hw/msp430_per_decoder.sv
  - hw/msp430_watchdog.sv
  - hw/msp430_multiplier.sv
  - hw/msp430_per_rdata.sv
  - hw/msp430_per_top.sv
  - target: simulation
    files:
      - tb/msp430_per_props.sv
      - tb/tb_msp430_per.sv

//--- tb/tb_msp430_per.sv
// Testbench for the peripheral subsystem, replays bus operations from the test file
`timescale 1ns/1ps
`default_nettype none

module tb_msp430_per import msp430_per_pkg::*; ();

  logic      mclk;
  logic      arst_n;
  per_req_t  per_req;
  per_word_t ext_per_dout;
  logic      wdt_irq_acc;
  per_word_t per_dout;
  logic      wdt_irq;
  logic      wdt_reset;

  int checks;                                 // Checks performed
  int value_errors;                           // Wrong values seen
  int timeout_errors;                         // Waits that ran out
  int other_errors;                           // File and format problems

  msp430_per_top UUT (
    .mclk         (mclk),
    .arst_n       (arst_n),
    .per_req      (per_req),
    .ext_per_dout (ext_per_dout),
    .wdt_irq_acc  (wdt_irq_acc),
    .per_dout     (per_dout),
    .wdt_irq      (wdt_irq),
    .wdt_reset    (wdt_reset)
  );

  // ====================
  // Clock
  // ====================
  initial begin
    mclk = 1'b0;
    forever #20 mclk = ~mclk;                 // 40 ns period
  end

  // ====================
  // Bus operations
  // ====================
  // All tasks start and end just after a falling edge
  task automatic bus_write(input [15:0] addr, input [15:0] data);
    per_req.addr = addr[14:1];                // Byte to word address
    per_req.din  = data;
    per_req.we   = 2'b11;                     // Full word
    per_req.en   = 1'b1;
    @(negedge mclk);
    per_req = '0;
  endtask

  task automatic bus_read_check(input [255:0] name, input [15:0] addr,
                                input [15:0] ext, input [15:0] expv);
    per_req.addr = addr[14:1];
    per_req.din  = '0;
    per_req.we   = 2'b00;                     // No lanes means read
    per_req.en   = 1'b1;
    ext_per_dout = ext;                       // External slave answers this cycle only
    @(negedge mclk);
    per_req      = '0;
    ext_per_dout = '0;
    checks++;
    assert (per_dout === expv) else begin
      $display("FAIL %0s: expected %h, actual %h", name, expv, per_dout);
      value_errors++;
    end
  endtask

  task automatic wait_for_irq(input [255:0] name, input [15:0] limit);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = wdt_irq;
    while (!seen && cycles < limit) begin
      @(negedge mclk);
      cycles++;
      seen = wdt_irq;
    end
    checks++;
    assert (seen) else begin
      $display("ERROR %0s: wdt_irq did not rise within %0d cycles", name, limit);
      timeout_errors++;
    end
  endtask

  task automatic wait_for_reset(input [255:0] name, input [15:0] limit);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = wdt_reset;                       // Limit 0 means it must be high now
    while (!seen && cycles < limit) begin
      @(negedge mclk);
      cycles++;
      seen = wdt_reset;
    end
    checks++;
    assert (seen) else begin
      $display("ERROR %0s: wdt_reset did not pulse within %0d cycles", name, limit);
      timeout_errors++;
    end
  endtask

  task automatic pulse_irq_acc(input [255:0] name, input [15:0] expv);
    wdt_irq_acc = 1'b1;
    @(negedge mclk);
    wdt_irq_acc = 1'b0;
    checks++;
    assert (wdt_irq === expv[0]) else begin
      $display("FAIL %0s: expected %h, actual %h", name, expv[0], wdt_irq);
      value_errors++;
    end
  endtask

  // One line of the test file: name op addr data expect
  task automatic run_line(input [8*128-1:0] line_buf);
    reg [255:0] name;
    reg [255:0] op;
    reg [15:0]  addr;
    reg [15:0]  data;
    reg [15:0]  expv;
    int         n;
    n = $sscanf(line_buf, "%s %s %h %h %h", name, op, addr, data, expv);
    if (n <= 0 || name == "#") begin
      return;                                 // Blank or comment
    end
    if (n != 5) begin
      $display("ERROR: test line %0s has %0d fields instead of 5", name, n);
      other_errors++;
    end else if (op == "wr") begin
      bus_write(addr, data);
    end else if (op == "rd") begin
      bus_read_check(name, addr, data, expv);
    end else if (op == "irq") begin
      wait_for_irq(name, data);               // Data column is the limit
    end else if (op == "rst") begin
      wait_for_reset(name, data);
    end else if (op == "ack") begin
      pulse_irq_acc(name, expv);
    end else begin
      $display("ERROR: test %0s has an unknown operation %0s", name, op);
      other_errors++;
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin : main
    int              fd;
    reg [8*128-1:0]  line_buf;
    checks         = 0;
    value_errors   = 0;
    timeout_errors = 0;
    other_errors   = 0;
    per_req        = '0;
    ext_per_dout   = '0;
    wdt_irq_acc    = 1'b0;
    arst_n         = 1'b0;
    repeat (4) @(posedge mclk);               // Reset for 4 cycles
    @(negedge mclk);
    arst_n = 1'b1;

    fd = $fopen("tb/msp430_per_tests.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open the test file tb/msp430_per_tests.txt");
      other_errors++;
    end else begin
      line_buf = '0;
      while ($fgets(line_buf, fd) != 0) begin
        run_line(line_buf);
        line_buf = '0;
      end
      $fclose(fd);
    end

    $display("Checks: %0d, value errors: %0d, timeouts: %0d, other errors: %0d",
             checks, value_errors, timeout_errors, other_errors);
    if (value_errors + timeout_errors + other_errors == 0 && checks > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/msp430_per_props.sv
// Concurrent assertions on the peripheral top, attached to every instance by bind
`timescale 1ns/1ps
`default_nettype none

module msp430_per_props import msp430_per_pkg::*; (
  input logic      mclk,
  input logic      arst_n,
  input per_req_t  per_req,                   // Raw bus request at the top
  input per_sel_t  per_sel,                   // Decoded access inside the top
  input per_word_t per_dout,
  input logic      wdt_irq,
  input logic      wdt_reset
);

  logic ie_model;                             // WDTIE as written over the bus

  // ====================
  // Reference state
  // ====================
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      ie_model <= 1'b0;
    end else if (per_req.en && per_req.we[0] && per_req.addr == 14'h0000) begin
      ie_model <= per_req.din[0];             // IE1 bit 0 written
    end
  end

  // ====================
  // Properties
  // ====================
  assert property (@(posedge mclk) disable iff (!arst_n) wdt_reset |=> !wdt_reset)
    else $error("wdt_reset high for two cycles in a row");

  assert property (@(posedge mclk) disable iff (!arst_n) wdt_irq |-> ie_model)
    else $error("wdt_irq high while WDTIE is clear");

  // Read bus idles at zero
  assert property (@(posedge mclk) disable iff (!arst_n) !per_sel.rd |=> (per_dout == '0))
    else $error("per_dout not zero after a cycle without a read");

endmodule

bind msp430_per_top msp430_per_props props (
  .mclk      (mclk),
  .arst_n    (arst_n),
  .per_req   (per_req),
  .per_sel   (per_sel),
  .per_dout  (per_dout),
  .wdt_irq   (wdt_irq),
  .wdt_reset (wdt_reset)
);

`default_nettype wire

//--- hw/msp430_per_top.sv
// Peripheral subsystem top: decoder, watchdog, multiplier and read bus on mclk
`timescale 1ns/1ps
`default_nettype none

module msp430_per_top import msp430_per_pkg::*; #(
  parameter logic [15:0] WDT_BASE      = 16'h0120, // WDTCTL byte address
  parameter logic [15:0] MPY_BASE      = 16'h0130, // MPY byte address
  parameter int          WDT_CNT_WIDTH = 16        // Watchdog counter width
) (
  input  logic      mclk,                     // Main clock
  input  logic      arst_n,                   // Async reset, active low
  input  per_req_t  per_req,                  // Peripheral bus request
  input  per_word_t ext_per_dout,             // External peripheral read word
  input  logic      wdt_irq_acc,              // Watchdog interrupt accepted
  output per_word_t per_dout,                 // Registered read data
  output logic      wdt_irq,                  // Watchdog interval interrupt
  output logic      wdt_reset                 // Watchdog reset pulse
);

  per_sel_t  per_sel;                         // Decoded access to peripherals
  per_word_t wdt_dout;
  per_word_t mpy_dout;

  // ====================
  // Input side
  // ====================
  msp430_per_decoder #(
    .WDT_BASE (WDT_BASE),
    .MPY_BASE (MPY_BASE)
  ) decoder (
    .per_req  (per_req),                      // Raw request
    .per_sel  (per_sel)                       // One-hot select and strobes
  );

  // ====================
  // Peripherals
  // ====================
  msp430_watchdog #(
    .WDT_CNT_WIDTH (WDT_CNT_WIDTH)
  ) watchdog (
    .mclk        (mclk),
    .arst_n      (arst_n),
    .per_sel     (per_sel),
    .per_din     (per_req.din),               // Write data straight from bus
    .wdt_irq_acc (wdt_irq_acc),
    .per_dout    (wdt_dout),
    .wdt_irq     (wdt_irq),
    .wdt_reset   (wdt_reset)
  );

  msp430_multiplier multiplier (
    .mclk        (mclk),
    .arst_n      (arst_n),
    .per_sel     (per_sel),
    .per_din     (per_req.din),
    .per_dout    (mpy_dout)
  );

  // ====================
  // Output side
  // ====================
  msp430_per_rdata per_rdata (
    .mclk        (mclk),
    .arst_n      (arst_n),
    .wdt_dout    (wdt_dout),
    .mpy_dout    (mpy_dout),
    .ext_dout    (ext_per_dout),              // Passed through when unmapped
    .per_dout    (per_dout)
  );

endmodule

`default_nettype wire

//--- hw/msp430_per_rdata.sv
// Peripheral read bus merging all read words into one registered output
`timescale 1ns/1ps
`default_nettype none

module msp430_per_rdata import msp430_per_pkg::*; (
  input  logic      mclk,                     // Main clock
  input  logic      arst_n,                   // Async reset, active low
  input  per_word_t wdt_dout,                 // Watchdog and SFR read word
  input  per_word_t mpy_dout,                 // Multiplier read word
  input  per_word_t ext_dout,                 // External peripheral read word
  output per_word_t per_dout                  // Registered read data
);

  per_word_t dout_or;                         // Combined sources

  // ====================
  // Merge and register
  // ====================
  // Sources drive zero unless selected, so OR is the mux
  assign dout_or = wdt_dout | mpy_dout | ext_dout;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      per_dout <= '0;
    end else begin
      per_dout <= dout_or;                    // Valid one cycle after the read
    end
  end

endmodule

`default_nettype wire

//--- hw/msp430_multiplier.sv
// Hardware multiplier with MPY, MPYS and MAC modes and RESLO/RESHI/SUMEXT results
`timescale 1ns/1ps
`default_nettype none

module msp430_multiplier import msp430_per_pkg::*; (
  input  logic      mclk,                     // Main clock
  input  logic      arst_n,                   // Async reset, active low
  input  per_sel_t  per_sel,                  // Decoded access
  input  per_word_t per_din,                  // Write data
  output per_word_t per_dout                  // Read word, zero when not selected
);

  per_word_t          op1;                    // Operand 1
  per_word_t          op2;                    // Operand 2
  per_word_t          reslo;
  per_word_t          reshi;
  per_word_t          sumext;
  logic               op_signed;              // MPYS mode
  logic               op_acc;                 // MAC mode
  logic               calc_go;                // OP2 written last cycle
  logic               any_wr;
  logic               op1_wr;
  logic signed [16:0] op1_ext;                // Operands with mode sign bit
  logic signed [16:0] op2_ext;
  logic signed [33:0] product;
  logic [32:0]        acc_sum;                // Accumulate with carry
  logic [31:0]        res_nxt;                // Next RESHI:RESLO
  per_word_t          sumext_nxt;

  // ====================
  // Operand registers
  // ====================
  assign any_wr = |per_sel.wr;
  assign op1_wr = any_wr & (per_sel.sel[REG_MPY] | per_sel.sel[REG_MPYS] | per_sel.sel[REG_MAC]);

  always_ff @(posedge mclk) begin
    if (op1_wr)                           op1 <= per_din;
    if (any_wr && per_sel.sel[REG_OP2])   op2 <= per_din;
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      op_signed <= 1'b0;
      op_acc    <= 1'b0;
      calc_go   <= 1'b0;
    end else begin
      if (op1_wr) begin
        op_signed <= per_sel.sel[REG_MPYS];
        op_acc    <= per_sel.sel[REG_MAC];
      end
      calc_go <= any_wr & per_sel.sel[REG_OP2]; // Compute on the next edge
    end
  end

  // ====================
  // Datapath
  // ====================
  assign op1_ext = {op_signed & op1[15], op1};
  assign op2_ext = {op_signed & op2[15], op2};
  assign product = op1_ext * op2_ext;         // 17x17 signed, exact
  assign acc_sum = {1'b0, reshi, reslo} + {1'b0, product[31:0]};
  assign res_nxt = op_acc ? acc_sum[31:0] : product[31:0];

  always_comb begin
    if (op_acc) begin
      sumext_nxt = {15'h0000, acc_sum[32]};   // MAC carry
    end else if (op_signed && product[33]) begin
      sumext_nxt = 16'hFFFF;                  // Negative signed product
    end else begin
      sumext_nxt = 16'h0000;
    end
  end

  // ====================
  // Result registers
  // ====================
  always_ff @(posedge mclk) begin
    if (calc_go) begin
      reslo  <= res_nxt[15:0];
      reshi  <= res_nxt[31:16];
      sumext <= sumext_nxt;
    end else begin
      if (any_wr && per_sel.sel[REG_RESLO]) reslo <= per_din; // MAC preload
      if (any_wr && per_sel.sel[REG_RESHI]) reshi <= per_din;
    end
  end

  // Result forwarded while it is being loaded
  always_comb begin
    per_dout = '0;
    if (per_sel.rd) begin
      if (per_sel.sel[REG_MPY] | per_sel.sel[REG_MPYS] | per_sel.sel[REG_MAC])
        per_dout = op1;
      if (per_sel.sel[REG_OP2])    per_dout = per_dout | op2;
      if (per_sel.sel[REG_RESLO])  per_dout = per_dout | (calc_go ? res_nxt[15:0] : reslo);
      if (per_sel.sel[REG_RESHI])  per_dout = per_dout | (calc_go ? res_nxt[31:16] : reshi);
      if (per_sel.sel[REG_SUMEXT]) per_dout = per_dout | (calc_go ? sumext_nxt : sumext);
    end
  end

endmodule

`default_nettype wire

//--- hw/msp430_watchdog.sv
// Watchdog timer with WDTCTL, interval counter and the WDTIE / WDTIFG SFR bits
`timescale 1ns/1ps
`default_nettype none

module msp430_watchdog import msp430_per_pkg::*; #(
  parameter int WDT_CNT_WIDTH = 16            // Counter width, at least 10
) (
  input  logic      mclk,                     // Main clock
  input  logic      arst_n,                   // Async reset, active low
  input  per_sel_t  per_sel,                  // Decoded access
  input  per_word_t per_din,                  // Write data
  input  logic      wdt_irq_acc,              // Interrupt accepted
  output per_word_t per_dout,                 // Read word, zero when not selected
  output logic      wdt_irq,                  // Interval interrupt level
  output logic      wdt_reset                 // One-cycle reset request
);

  logic [7:0]               wdtctl;           // Low byte of WDTCTL
  logic                     wdtie;            // IE1 bit 0
  logic                     wdtifg;           // IFG1 bit 0
  logic [WDT_CNT_WIDTH-1:0] wdt_cnt;          // Interval counter
  logic [WDT_CNT_WIDTH-1:0] cnt_inc;          // Counter plus one
  logic                     ctl_wr;           // Any write to WDTCTL
  logic                     pw_ok;            // Password matches
  logic                     cnt_clr;          // CNTCL written
  logic                     cnt_run;          // Not held
  logic                     wdt_expire;       // Interval end this cycle
  logic                     ie_wr;            // IE1 low byte write
  logic                     ifg_wr;           // IFG1 low byte write
  logic                     ifg_set;
  logic                     ifg_clr;
  int                       tap_idx;          // Counter bit marking the interval

  // ====================
  // Control decode
  // ====================
  assign ctl_wr  = per_sel.sel[REG_WDTCTL] & (|per_sel.wr);
  assign pw_ok   = (per_din[15:8] == WDT_PASSWORD);
  assign cnt_clr = ctl_wr & pw_ok & per_din[WDT_CNTCL];
  assign cnt_run = ~wdtctl[WDT_HOLD];
  assign ie_wr   = per_sel.sel[REG_IE1] & per_sel.wr[0];
  assign ifg_wr  = per_sel.sel[REG_IFG1] & per_sel.wr[0];

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      wdtctl <= 8'h00;                        // Watchdog mode, running, longest
    end else if (ctl_wr && pw_ok) begin
      wdtctl            <= per_din[7:0];
      wdtctl[WDT_CNTCL] <= 1'b0;              // Always reads back zero
    end
  end

  // ====================
  // Interval counter
  // ====================
  assign cnt_inc = wdt_cnt + 1'b1;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      wdt_cnt <= '0;
    end else if (cnt_clr) begin
      wdt_cnt <= '0;
    end else if (cnt_run) begin
      wdt_cnt <= cnt_inc;
    end
  end

  always_comb begin
    case (wdtctl[WDT_IS +: 2])
      2'd0:    tap_idx = WDT_CNT_WIDTH - 1;   // Longest interval
      2'd1:    tap_idx = WDT_CNT_WIDTH - 3;
      2'd2:    tap_idx = 9;                   // 512 cycles
      default: tap_idx = 6;                   // 64 cycles
    endcase
  end

  // Tap bit toggles once every 2**tap_idx counts
  assign wdt_expire = cnt_run & ~cnt_clr & (cnt_inc[tap_idx] ^ wdt_cnt[tap_idx]);

  // ====================
  // SFR bits and outputs
  // ====================
  assign ifg_set = wdt_expire | (ifg_wr & per_din[0]);
  assign ifg_clr = wdt_irq_acc | (ifg_wr & ~per_din[0]);

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      wdtie     <= 1'b0;
      wdtifg    <= 1'b0;
      wdt_reset <= 1'b0;
    end else begin
      if (ie_wr) wdtie <= per_din[0];
      if (ifg_set) begin
        wdtifg <= 1'b1;                       // Set wins over clear
      end else if (ifg_clr) begin
        wdtifg <= 1'b0;
      end
      // Bad password or watchdog-mode expiry
      wdt_reset <= (ctl_wr & ~pw_ok) | (wdt_expire & ~wdtctl[WDT_TMSEL]);
    end
  end

  assign wdt_irq = wdtctl[WDT_TMSEL] & wdtie & wdtifg; // Interval mode only

  always_comb begin
    per_dout = '0;
    if (per_sel.rd) begin
      if (per_sel.sel[REG_WDTCTL]) per_dout = {WDT_READ_KEY, wdtctl};
      if (per_sel.sel[REG_IE1])    per_dout = per_dout | {15'h0000, wdtie};
      if (per_sel.sel[REG_IFG1])   per_dout = per_dout | {15'h0000, wdtifg};
    end
  end

endmodule

`default_nettype wire

//--- hw/msp430_per_decoder.sv
// Address decoder turning a peripheral bus request into one-hot register selects
`timescale 1ns/1ps
`default_nettype none

module msp430_per_decoder import msp430_per_pkg::*; #(
  parameter logic [15:0] WDT_BASE = 16'h0120, // WDTCTL byte address
  parameter logic [15:0] MPY_BASE = 16'h0130  // MPY byte address
) (
  input  per_req_t per_req,                   // Bus request
  output per_sel_t per_sel                    // Decoded access
);

  // ====================
  // Word addresses
  // ====================
  localparam logic [13:0] IE1_ADDR  = 14'h0000; // SFR words at the bottom
  localparam logic [13:0] IFG1_ADDR = 14'h0001;
  localparam logic [13:0] WDT_ADDR  = WDT_BASE[14:1]; // Byte to word
  localparam logic [13:0] MPY_ADDR  = MPY_BASE[14:1];

  logic [NUM_REGS-1:0] reg_hit;               // Address match per register

  // ====================
  // Address compare
  // ====================
  always_comb begin
    reg_hit = '0;
    reg_hit[REG_IE1]    = (per_req.addr == IE1_ADDR);
    reg_hit[REG_IFG1]   = (per_req.addr == IFG1_ADDR);
    reg_hit[REG_WDTCTL] = (per_req.addr == WDT_ADDR);
    // Multiplier block, MACS slot at +3 left unmapped
    reg_hit[REG_MPY]    = (per_req.addr == MPY_ADDR);
    reg_hit[REG_MPYS]   = (per_req.addr == MPY_ADDR + 14'd1);
    reg_hit[REG_MAC]    = (per_req.addr == MPY_ADDR + 14'd2);
    reg_hit[REG_OP2]    = (per_req.addr == MPY_ADDR + 14'd4);
    reg_hit[REG_RESLO]  = (per_req.addr == MPY_ADDR + 14'd5);
    reg_hit[REG_RESHI]  = (per_req.addr == MPY_ADDR + 14'd6);
    reg_hit[REG_SUMEXT] = (per_req.addr == MPY_ADDR + 14'd7);
  end

  // ====================
  // Strobes
  // ====================
  assign per_sel.sel = reg_hit & {NUM_REGS{per_req.en}}; // Nothing selected when idle
  assign per_sel.rd  = per_req.en & ~(|per_req.we);      // Read = enable without lanes
  assign per_sel.wr  = per_req.we & {2{per_req.en}};     // Lanes only with enable

endmodule

`default_nettype wire

//--- hw/msp430_per_pkg.sv
// Shared peripheral bus types, register map enumeration and watchdog constants
`default_nettype none

package msp430_per_pkg;

  // ====================
  // Bus types
  // ====================
  typedef logic [15:0] per_word_t;           // Data word on every bus

  typedef struct packed {
    logic [13:0] addr;                       // Word address
    per_word_t   din;                        // Write data
    logic [1:0]  we;                         // Byte lane write enables
    logic        en;                         // Access strobe
  } per_req_t;

  // Decoded registers, also the bit index into the one-hot select
  typedef enum logic [3:0] {
    REG_IE1,                                 // SFR interrupt enable
    REG_IFG1,                                // SFR interrupt flags
    REG_WDTCTL,                              // Watchdog control
    REG_MPY,                                 // Unsigned multiply operand 1
    REG_MPYS,                                // Signed multiply operand 1
    REG_MAC,                                 // Multiply-accumulate operand 1
    REG_OP2,                                 // Operand 2, starts the operation
    REG_RESLO,                               // Result low word
    REG_RESHI,                               // Result high word
    REG_SUMEXT                               // Sign / carry extension
  } per_reg_e;

  localparam int NUM_REGS = 10;              // Entries in per_reg_e

  typedef struct packed {
    logic [NUM_REGS-1:0] sel;                // One-hot register select
    logic                rd;                 // Read strobe
    logic [1:0]          wr;                 // Write byte lanes
  } per_sel_t;

  // ====================
  // Watchdog
  // ====================
  localparam logic [7:0] WDT_PASSWORD = 8'h5A; // Required high byte on write
  localparam logic [7:0] WDT_READ_KEY = 8'h69; // High byte on read

  localparam int WDT_HOLD  = 7;              // Stop counter
  localparam int WDT_TMSEL = 4;              // 1 = interval mode
  localparam int WDT_CNTCL = 3;              // Counter clear, self clearing
  localparam int WDT_IS    = 0;              // Interval select, 2 bits from here

endpackage

`default_nettype wire
